// ==== design/axi_delay_pkg.sv ====
// AXI delayer package with bus widths, delay settings and packed channel and bundle types
package axi_delay_pkg;

  // AXI field widths, matching the bus this delayer sits on
  localparam int addr_width = 32;
  localparam int data_width = 32;
  localparam int id_width   = 8;
  localparam int user_width = 8;

  // One strobe bit per data byte
  localparam int strb_width = data_width / 8;

  // Minimum number of cycles a beat stays inside a stage
  localparam int fixed_delay = 2;

  // Number of beats each stage can hold at once
  localparam int stage_depth = 4;

  // Derived widths for the stage pointers, fill count and age counters
  localparam int ptr_width   = (stage_depth > 1) ? $clog2(stage_depth) : 1;
  localparam int count_width = $clog2(stage_depth + 1);
  localparam int age_width   = (fixed_delay > 0) ? $clog2(fixed_delay + 1) : 1;

  // Width of the stall pattern LFSR
  localparam int lfsr_width = 16;

  // Address beat, shared by the write and read address channels
  typedef struct packed {
    logic [id_width-1:0]   id;
    logic [addr_width-1:0] addr;
    logic [7:0]            len;
    logic [2:0]            size;
    logic [1:0]            burst;
    logic [user_width-1:0] user;
  } aw_chan_t;

  // The read address channel carries the same layout
  typedef aw_chan_t ar_chan_t;

  // Write data beat
  typedef struct packed {
    logic [data_width-1:0] data;
    logic [strb_width-1:0] strb;
    logic                  last;
    logic [user_width-1:0] user;
  } w_chan_t;

  // Write response beat
  typedef struct packed {
    logic [id_width-1:0]   id;
    logic [1:0]            resp;
    logic [user_width-1:0] user;
  } b_chan_t;

  // Read data beat
  typedef struct packed {
    logic [id_width-1:0]   id;
    logic [data_width-1:0] data;
    logic [1:0]            resp;
    logic                  last;
    logic [user_width-1:0] user;
  } r_chan_t;

  // Everything a manager drives toward a subordinate
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    ar_chan_t ar;
    logic     ar_valid;
    logic     b_ready;
    logic     r_ready;
  } axi_req_t;

  // Everything a subordinate drives back toward the manager
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    logic    ar_ready;
    b_chan_t b;
    logic    b_valid;
    r_chan_t r;
    logic    r_valid;
  } axi_resp_t;

endpackage

// ==== design/stall_gen.sv ====
// Pseudo-random stall source for one channel, built on a 16-bit Fibonacci LFSR
`timescale 1ns/1ps

module stall_gen
  import axi_delay_pkg::*;
#(
  // Start value of the LFSR, any nonzero value works
  parameter logic [lfsr_width-1:0] seed = 16'hace1
) (
  input  logic clk,
  input  logic rst_n,
  input  logic advance,
  output logic stall
);

  logic [lfsr_width-1:0] lfsr_q;
  logic                  feedback;

  // Taps 16, 14, 13 and 11 give a maximal-length sequence
  // Bit 15 here is tap 16, counting taps from one
  assign feedback = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

  // The register only moves while the stage is trying to release a beat
  // This keeps the stall pattern tied to release attempts and not to idle time
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lfsr_q <= seed;
    end else if (advance) begin
      lfsr_q <= {lfsr_q[lfsr_width-2:0], feedback};
    end
  end

  // Both low bits set happens about one time in four
  assign stall = lfsr_q[1] & lfsr_q[0];

endmodule

// ==== design/chan_delay_stage.sv ====
// Valid/ready delay stage that holds each beat for a fixed time plus random stalls
`timescale 1ns/1ps

module chan_delay_stage
  import axi_delay_pkg::*;
#(
  // Channel payload, one of the package channel structs
  parameter type payload_t = logic,
  // Seed for this stage's stall generator
  parameter logic [lfsr_width-1:0] seed = 16'hace1
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  // Beat storage and one age counter per entry
  payload_t             mem [stage_depth];
  logic [age_width-1:0] age_q [stage_depth];

  // Circular buffer pointers and fill level
  logic [ptr_width-1:0]   head_q;
  logic [ptr_width-1:0]   tail_q;
  logic [count_width-1:0] count_q;

  // Set once the head has been offered downstream and not yet taken
  logic presented_q;

  logic push;
  logic pop;
  logic head_old;
  logic stall;
  logic advance;

  // Input handshake and storage

  // The stage only refuses a beat when every entry is occupied
  assign in_ready = (count_q != count_width'(stage_depth));
  assign push     = in_valid & in_ready;

  // Each accepted beat is written at the tail
  always_ff @(posedge clk) begin
    if (push) begin
      mem[tail_q] <= in_data;
    end
  end

  // Age tracking and release decision

  // Every age counter climbs by one per cycle and stops at the fixed delay
  // A newly written entry restarts at zero on the cycle it is accepted
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < stage_depth; i++) begin
        age_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < stage_depth; i++) begin
        if (push && (tail_q == ptr_width'(i))) begin
          age_q[i] <= '0;
        end else if (age_q[i] < age_width'(fixed_delay)) begin
          age_q[i] <= age_q[i] + 1'b1;
        end
      end
    end
  end

  // The head has served its minimum time and may be released
  assign head_old = (count_q != '0) && (age_q[head_q] >= age_width'(fixed_delay));

  // The stall pattern only steps while a release is being attempted
  assign advance = head_old & ~presented_q;

  stall_gen #(
    .seed (seed)
  ) stall_gen0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .advance (advance),
    .stall   (stall)
  );

  // Output handshake

  // A stall can only hold back the first offer, a raised valid stays raised
  assign out_valid = presented_q | (head_old & ~stall);
  assign out_data  = mem[head_q];
  assign pop       = out_valid & out_ready;

  // Remember an offer that was not taken so valid stays high until ready
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      presented_q <= 1'b0;
    end else if (pop) begin
      presented_q <= 1'b0;
    end else if (out_valid) begin
      presented_q <= 1'b1;
    end
  end

  // Pointer and fill level bookkeeping
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (push) begin
        // Wrap explicitly so a depth that is not a power of two still works
        if (tail_q == ptr_width'(stage_depth - 1)) begin
          tail_q <= '0;
        end else begin
          tail_q <= tail_q + 1'b1;
        end
      end
      if (pop) begin
        if (head_q == ptr_width'(stage_depth - 1)) begin
          head_q <= '0;
        end else begin
          head_q <= head_q + 1'b1;
        end
      end
      // Simultaneous push and pop leave the fill level unchanged
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// ==== design/axi_delayer.sv ====
// AXI4 channel delayer that places one delay stage on each of the five channels
`timescale 1ns/1ps

module axi_delayer
  import axi_delay_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  // Manager side, requests come in and responses go out
  input  axi_req_t  slv_req,
  output axi_resp_t slv_resp,
  // Subordinate side, requests go out and responses come in
  output axi_req_t  mst_req,
  input  axi_resp_t mst_resp
);

  // Write address travels downstream
  chan_delay_stage #(
    .payload_t (aw_chan_t),
    .seed      (16'hace1)
  ) aw_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (slv_req.aw_valid),
    .in_ready  (slv_resp.aw_ready),
    .in_data   (slv_req.aw),
    .out_valid (mst_req.aw_valid),
    .out_ready (mst_resp.aw_ready),
    .out_data  (mst_req.aw)
  );

  // Write data travels downstream
  chan_delay_stage #(
    .payload_t (w_chan_t),
    .seed      (16'h1d2b)
  ) w_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (slv_req.w_valid),
    .in_ready  (slv_resp.w_ready),
    .in_data   (slv_req.w),
    .out_valid (mst_req.w_valid),
    .out_ready (mst_resp.w_ready),
    .out_data  (mst_req.w)
  );

  // Read address travels downstream
  chan_delay_stage #(
    .payload_t (ar_chan_t),
    .seed      (16'h5a37)
  ) ar_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (slv_req.ar_valid),
    .in_ready  (slv_resp.ar_ready),
    .in_data   (slv_req.ar),
    .out_valid (mst_req.ar_valid),
    .out_ready (mst_resp.ar_ready),
    .out_data  (mst_req.ar)
  );

  // Write response comes back upstream
  // Its ready toward the subordinate is the stage's own input ready
  chan_delay_stage #(
    .payload_t (b_chan_t),
    .seed      (16'hb3c9)
  ) b_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (mst_resp.b_valid),
    .in_ready  (mst_req.b_ready),
    .in_data   (mst_resp.b),
    .out_valid (slv_resp.b_valid),
    .out_ready (slv_req.b_ready),
    .out_data  (slv_resp.b)
  );

  // Read data comes back upstream
  chan_delay_stage #(
    .payload_t (r_chan_t),
    .seed      (16'h7e45)
  ) r_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (mst_resp.r_valid),
    .in_ready  (mst_req.r_ready),
    .in_data   (mst_resp.r),
    .out_valid (slv_resp.r_valid),
    .out_ready (slv_req.r_ready),
    .out_data  (slv_resp.r)
  );

endmodule

// ==== tests/tb_clock_gen.sv ====
// Testbench clock and reset source with a 4 ns clock and reset held for 8 cycles
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter realtime clk_period   = 4.0,
  parameter int      reset_cycles = 8
) (
  output logic clk,
  output logic rst_n
);

  // Free running clock, starts low
  initial begin
    clk = 1'b0;
    forever #(clk_period / 2.0) clk = ~clk;
  end

  // Reset is released on a rising edge, like every other driven input
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// ==== tests/tb_axi_checks.svh ====
// Compare tasks for the AXI channel structs and the error counters they update
`ifndef TB_AXI_CHECKS_SVH
`define TB_AXI_CHECKS_SVH

  // Wrong values and other failures are counted apart
  int value_errors = 0;
  int other_errors = 0;

  task automatic report_failure(input string msg);
    other_errors++;
    $display("failure at %0t: %s", $time, msg);
  endtask

  task automatic check_aw(input string sig, input aw_chan_t exp, input aw_chan_t act);
    if (act !== exp) begin
      value_errors++;
      $display("error %s expected 0x%h actual 0x%h", sig, exp, act);
    end
  endtask

  task automatic check_ar(input string sig, input ar_chan_t exp, input ar_chan_t act);
    if (act !== exp) begin
      value_errors++;
      $display("error %s expected 0x%h actual 0x%h", sig, exp, act);
    end
  endtask

  task automatic check_w(input string sig, input w_chan_t exp, input w_chan_t act);
    if (act !== exp) begin
      value_errors++;
      $display("error %s expected 0x%h actual 0x%h", sig, exp, act);
    end
  endtask

  task automatic check_b(input string sig, input b_chan_t exp, input b_chan_t act);
    if (act !== exp) begin
      value_errors++;
      $display("error %s expected 0x%h actual 0x%h", sig, exp, act);
    end
  endtask

  task automatic check_r(input string sig, input r_chan_t exp, input r_chan_t act);
    if (act !== exp) begin
      value_errors++;
      $display("error %s expected 0x%h actual 0x%h", sig, exp, act);
    end
  endtask

  // Single control bits such as valid, ready and last
  task automatic check_bit(input string sig, input logic exp, input logic act);
    if (act !== exp) begin
      value_errors++;
      $display("error %s expected 0x%h actual 0x%h", sig, exp, act);
    end
  endtask

  task automatic check_id(input string sig, input logic [id_width-1:0] exp,
                          input logic [id_width-1:0] act);
    if (act !== exp) begin
      value_errors++;
      $display("error %s expected 0x%h actual 0x%h", sig, exp, act);
    end
  endtask

`endif

// ==== tests/tb_axi_delayer.sv ====
// Testbench for the AXI delayer with random manager and subordinate models
`timescale 1ns/1ps

module tb_axi_delayer
  import axi_delay_pkg::*;
;

  localparam int num_aw = 200;
  localparam int num_w  = 200;
  localparam int num_ar = 100;
  // B answers every AW and each AR yields up to four R beats
  localparam int total_beats = num_aw + num_w + num_ar + num_aw + 4 * num_ar;
  localparam realtime clk_period = 4.0;
  // Subordinate holds every ready low inside this cycle window
  localparam int bp_start = 80;
  localparam int bp_end   = 200;

  logic      clk;
  logic      rst_n;
  axi_req_t  slv_req;
  axi_resp_t slv_resp;
  axi_req_t  mst_req;
  axi_resp_t mst_resp;

  `include "tb_axi_checks.svh"

  tb_clock_gen #(.clk_period(clk_period), .reset_cycles(8)) clock_gen0 (
    .clk   (clk),
    .rst_n (rst_n)
  );

  axi_delayer dut0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .slv_req  (slv_req),
    .slv_resp (slv_resp),
    .mst_req  (mst_req),
    .mst_resp (mst_resp)
  );

  logic [31:0] lfsr_state = 32'hdc0a451f;
  int cycle = 0;
  int aw_sent = 0;
  int w_sent = 0;
  int ar_sent = 0;
  int r_left = 0;
  int r_beat = 0;
  bit saw_aw_full = 0;
  bit saw_w_full = 0;
  ar_chan_t cur_ar;

  // Reference queues with the acceptance cycle of each beat
  aw_chan_t aw_q[$];
  w_chan_t  w_q[$];
  ar_chan_t ar_q[$];
  b_chan_t  b_q[$];
  r_chan_t  r_q[$];
  int aw_t[$];
  int w_t[$];
  int ar_t[$];
  int b_t[$];
  int r_t[$];
  // AW ids in issue order and the R burst lengths for response pairing
  logic [id_width-1:0] b_id_q[$];
  int r_len_q[$];
  // Work still owed by the subordinate model
  logic [id_width-1:0] b_pend[$];
  ar_chan_t ar_pend[$];

  // Held offers on the five DUT outputs, for the stability check
  bit aw_hold = 0;
  bit w_hold = 0;
  bit ar_hold = 0;
  bit b_hold = 0;
  bit r_hold = 0;
  aw_chan_t aw_prev;
  w_chan_t  w_prev;
  ar_chan_t ar_prev;
  b_chan_t  b_prev;
  r_chan_t  r_prev;

  // Fibonacci LFSR with taps 32, 22, 2 and 1, stepped once per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      bits = {bits[30:0], fb};
    end
    return bits;
  endfunction

  function automatic aw_chan_t rand_addr_beat();
    aw_chan_t a;
    a.id    = id_width'(take_bits(id_width));
    a.addr  = addr_width'(take_bits(addr_width));
    a.len   = 8'(take_bits(8));
    a.size  = 3'(take_bits(3));
    a.burst = 2'(take_bits(2));
    a.user  = user_width'(take_bits(user_width));
    return a;
  endfunction

  function automatic w_chan_t rand_w_beat();
    w_chan_t d;
    d.data = data_width'(take_bits(data_width));
    d.strb = strb_width'(take_bits(strb_width));
    d.last = 1'(take_bits(1));
    d.user = user_width'(take_bits(user_width));
    return d;
  endfunction

  // Minimum latency from input acceptance to output transfer
  task automatic check_delay(input string chan, input int accepted);
    if (cycle - accepted < fixed_delay) begin
      report_failure($sformatf("%s beat left after %0d cycles, sooner than the fixed delay",
                               chan, cycle - accepted));
    end
  endtask

  task automatic check_reset_state();
    check_bit("mst_req.aw_valid", 1'b0, mst_req.aw_valid);
    check_bit("mst_req.w_valid", 1'b0, mst_req.w_valid);
    check_bit("mst_req.ar_valid", 1'b0, mst_req.ar_valid);
    check_bit("slv_resp.b_valid", 1'b0, slv_resp.b_valid);
    check_bit("slv_resp.r_valid", 1'b0, slv_resp.r_valid);
    check_bit("slv_resp.aw_ready", 1'b1, slv_resp.aw_ready);
    check_bit("slv_resp.w_ready", 1'b1, slv_resp.w_ready);
    check_bit("slv_resp.ar_ready", 1'b1, slv_resp.ar_ready);
    // The B and R stages are empty too, so they accept toward the subordinate
    check_bit("mst_req.b_ready", 1'b1, mst_req.b_ready);
    check_bit("mst_req.r_ready", 1'b1, mst_req.r_ready);
  endtask

  // Manager side: issue AW, W and AR, and randomize B and R ready
  task automatic drive_manager();
    if (slv_req.aw_valid && slv_resp.aw_ready) begin
      aw_q.push_back(slv_req.aw);
      aw_t.push_back(cycle);
      b_id_q.push_back(slv_req.aw.id);
      aw_sent++;
    end
    if (!slv_req.aw_valid || slv_resp.aw_ready) begin
      if (aw_sent < num_aw && take_bits(2) != 0) begin
        slv_req.aw       <= rand_addr_beat();
        slv_req.aw_valid <= 1'b1;
      end else begin
        slv_req.aw_valid <= 1'b0;
      end
    end
    if (slv_req.w_valid && slv_resp.w_ready) begin
      w_q.push_back(slv_req.w);
      w_t.push_back(cycle);
      w_sent++;
    end
    if (!slv_req.w_valid || slv_resp.w_ready) begin
      if (w_sent < num_w && take_bits(2) != 0) begin
        slv_req.w       <= rand_w_beat();
        slv_req.w_valid <= 1'b1;
      end else begin
        slv_req.w_valid <= 1'b0;
      end
    end
    if (slv_req.ar_valid && slv_resp.ar_ready) begin
      ar_q.push_back(slv_req.ar);
      ar_t.push_back(cycle);
      ar_sent++;
    end
    if (!slv_req.ar_valid || slv_resp.ar_ready) begin
      if (ar_sent < num_ar && take_bits(1) != 0) begin
        slv_req.ar       <= rand_addr_beat();
        slv_req.ar_valid <= 1'b1;
      end else begin
        slv_req.ar_valid <= 1'b0;
      end
    end
    slv_req.b_ready <= (take_bits(2) != 0);
    slv_req.r_ready <= (take_bits(2) != 0);
  endtask

  // Subordinate side: take requests, answer with B and R bursts
  task automatic drive_subordinate();
    b_chan_t b;
    r_chan_t r;
    bit      in_window;
    in_window = (cycle >= bp_start) && (cycle < bp_end);
    if (mst_req.aw_valid && mst_resp.aw_ready) begin
      b_pend.push_back(mst_req.aw.id);
    end
    if (mst_req.ar_valid && mst_resp.ar_ready) begin
      ar_pend.push_back(mst_req.ar);
    end
    mst_resp.aw_ready <= !in_window && (take_bits(2) != 0);
    mst_resp.w_ready  <= !in_window && (take_bits(2) != 0);
    mst_resp.ar_ready <= !in_window && (take_bits(2) != 0);
    if (mst_resp.b_valid && mst_req.b_ready) begin
      b_q.push_back(mst_resp.b);
      b_t.push_back(cycle);
    end
    if (!mst_resp.b_valid || mst_req.b_ready) begin
      if (b_pend.size() > 0 && take_bits(1) != 0) begin
        b.id   = b_pend.pop_front();
        b.resp = 2'(take_bits(2));
        b.user = user_width'(take_bits(user_width));
        mst_resp.b       <= b;
        mst_resp.b_valid <= 1'b1;
      end else begin
        mst_resp.b_valid <= 1'b0;
      end
    end
    if (mst_resp.r_valid && mst_req.r_ready) begin
      r_q.push_back(mst_resp.r);
      r_t.push_back(cycle);
    end
    if (!mst_resp.r_valid || mst_req.r_ready) begin
      // Start the next burst once the current one has been fully offered
      if (r_left == 0 && ar_pend.size() > 0) begin
        cur_ar = ar_pend.pop_front();
        r_left = int'(take_bits(2)) + 1;
        r_len_q.push_back(r_left);
      end
      if (r_left > 0 && take_bits(1) != 0) begin
        r.id   = cur_ar.id;
        r.data = data_width'(take_bits(data_width));
        r.resp = 2'(take_bits(2));
        r.last = (r_left == 1);
        r.user = user_width'(take_bits(user_width));
        mst_resp.r       <= r;
        mst_resp.r_valid <= 1'b1;
        r_left--;
      end else begin
        mst_resp.r_valid <= 1'b0;
      end
    end
  endtask

  // Output side: pop the reference queues and compare every delivered beat
  task automatic monitor_outputs();
    aw_chan_t aw_exp;
    w_chan_t  w_exp;
    ar_chan_t ar_exp;
    b_chan_t  b_exp;
    r_chan_t  r_exp;
    if (mst_req.aw_valid && mst_resp.aw_ready) begin
      if (aw_q.size() == 0) begin
        report_failure("AW beat delivered with no accepted beat waiting");
      end else begin
        aw_exp = aw_q.pop_front();
        check_aw("mst_req.aw", aw_exp, mst_req.aw);
        check_delay("AW", aw_t.pop_front());
      end
    end
    if (mst_req.w_valid && mst_resp.w_ready) begin
      if (w_q.size() == 0) begin
        report_failure("W beat delivered with no accepted beat waiting");
      end else begin
        w_exp = w_q.pop_front();
        check_w("mst_req.w", w_exp, mst_req.w);
        check_delay("W", w_t.pop_front());
      end
    end
    if (mst_req.ar_valid && mst_resp.ar_ready) begin
      if (ar_q.size() == 0) begin
        report_failure("AR beat delivered with no accepted beat waiting");
      end else begin
        ar_exp = ar_q.pop_front();
        check_ar("mst_req.ar", ar_exp, mst_req.ar);
        check_delay("AR", ar_t.pop_front());
      end
    end
    if (slv_resp.b_valid && slv_req.b_ready) begin
      if (b_q.size() == 0 || b_id_q.size() == 0) begin
        report_failure("B beat delivered with no accepted beat waiting");
      end else begin
        b_exp = b_q.pop_front();
        check_b("slv_resp.b", b_exp, slv_resp.b);
        check_delay("B", b_t.pop_front());
        // Responses come back in the order the writes were issued
        check_id("slv_resp.b.id", b_id_q.pop_front(), slv_resp.b.id);
      end
    end
    if (slv_resp.r_valid && slv_req.r_ready) begin
      if (r_q.size() == 0 || r_len_q.size() == 0) begin
        report_failure("R beat delivered with no accepted beat waiting");
      end else begin
        r_exp = r_q.pop_front();
        check_r("slv_resp.r", r_exp, slv_resp.r);
        check_delay("R", r_t.pop_front());
        r_beat++;
        check_bit("slv_resp.r.last", r_beat == r_len_q[0], slv_resp.r.last);
        if (r_beat == r_len_q[0]) begin
          void'(r_len_q.pop_front());
          r_beat = 0;
        end
      end
    end
  endtask

  // An offer that was not taken must still stand, with the same payload
  task automatic check_stability();
    if (aw_hold) begin
      check_bit("mst_req.aw_valid", 1'b1, mst_req.aw_valid);
      check_aw("mst_req.aw", aw_prev, mst_req.aw);
    end
    if (w_hold) begin
      check_bit("mst_req.w_valid", 1'b1, mst_req.w_valid);
      check_w("mst_req.w", w_prev, mst_req.w);
    end
    if (ar_hold) begin
      check_bit("mst_req.ar_valid", 1'b1, mst_req.ar_valid);
      check_ar("mst_req.ar", ar_prev, mst_req.ar);
    end
    if (b_hold) begin
      check_bit("slv_resp.b_valid", 1'b1, slv_resp.b_valid);
      check_b("slv_resp.b", b_prev, slv_resp.b);
    end
    if (r_hold) begin
      check_bit("slv_resp.r_valid", 1'b1, slv_resp.r_valid);
      check_r("slv_resp.r", r_prev, slv_resp.r);
    end
    aw_hold = mst_req.aw_valid && !mst_resp.aw_ready;
    w_hold  = mst_req.w_valid && !mst_resp.w_ready;
    ar_hold = mst_req.ar_valid && !mst_resp.ar_ready;
    b_hold  = slv_resp.b_valid && !slv_req.b_ready;
    r_hold  = slv_resp.r_valid && !slv_req.r_ready;
    aw_prev = mst_req.aw;
    w_prev  = mst_req.w;
    ar_prev = mst_req.ar;
    b_prev  = slv_resp.b;
    r_prev  = slv_resp.r;
  endtask

  function automatic bit all_done();
    return aw_sent == num_aw && w_sent == num_w && ar_sent == num_ar &&
           aw_q.size() == 0 && w_q.size() == 0 && ar_q.size() == 0 &&
           b_q.size() == 0 && r_q.size() == 0 && b_pend.size() == 0 &&
           ar_pend.size() == 0 && r_left == 0 && !mst_resp.b_valid && !mst_resp.r_valid;
  endfunction

  initial begin
    slv_req  = '0;
    mst_resp = '0;
  end

  // Reset state is checked once the first reset edge has gone by
  always @(posedge clk) begin
    if (!rst_n) begin
      if ($time > clk_period) begin
        check_reset_state();
      end
    end else begin
      // The first edge out of reset still sees the reset state
      if (cycle == 0) begin
        check_reset_state();
      end
      if (cycle >= bp_start && cycle < bp_end) begin
        if (!slv_resp.aw_ready) saw_aw_full = 1;
        if (!slv_resp.w_ready) saw_w_full = 1;
      end
      monitor_outputs();
      check_stability();
      drive_manager();
      drive_subordinate();
      cycle++;
    end
  end

  // Watchdog sized from the total beat count
  initial begin
    #(20 * total_beats * clk_period);
    $display("timeout: the run did not finish, %0d AW, %0d W and %0d AR accepted",
             aw_sent, w_sent, ar_sent);
    $display("Errors found");
    $finish;
  end

  initial begin
    @(posedge rst_n);
    while (!all_done()) @(posedge clk);
    repeat (4) @(posedge clk);
    if (!saw_aw_full || !saw_w_full) begin
      report_failure("input ready never fell while the subordinate held ready low");
    end
    if (b_id_q.size() != 0 || r_len_q.size() != 0) begin
      report_failure("responses missing at the manager side after all beats drained");
    end
    $display("value errors %0d, other errors %0d", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+tests
design/axi_delay_pkg.sv
design/stall_gen.sv
design/chan_delay_stage.sv
design/axi_delayer.sv
tests/tb_clock_gen.sv
tests/tb_axi_delayer.sv

// ==== Makefile ====
# Verilator build and run for the AXI delayer testbench

VERILATOR ?= verilator
TOP       ?= tb_axi_delayer
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and pass only if the pass message appears"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(wildcard design/*.sv tests/*.sv tests/*.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
